// File: id_pkg.sv
////////////////////////////////////////////////////////////
// Widths and encodings shared by the RV32I decode stage
// Referenced by scoped name from the RTL and the testbench
////////////////////////////////////////////////////////////

`default_nettype none

package id_pkg;

  // Datapath widths
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // Major opcodes of the supported classes
  typedef enum logic [6:0] {
    OPCODE_OP     = 7'h33,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_LUI    = 7'h37,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_JAL    = 7'h6f,
    OPCODE_BRANCH = 7'h63,
    OPCODE_LOAD   = 7'h03,
    OPCODE_STORE  = 7'h23
  } opcode_e;

  // ALU operations
  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    // Branch compares
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_CURRPC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I,
    IMM_B_S,
    IMM_B_B,
    IMM_B_U,
    IMM_B_J,
    IMM_B_INCR_PC
  } imm_b_sel_e;

  // Write-back source
  typedef enum logic {
    RF_WD_EX,
    RF_WD_LSU
  } rf_wd_sel_e;

  // Memory access size, as seen by the LSU
  typedef enum logic [1:0] {
    DT_WORD = 2'b00,
    DT_HALF = 2'b01,
    DT_BYTE = 2'b10
  } data_type_e;

endpackage

`default_nettype wire

// File: id_dec_if.sv
////////////////////////////////////////////////////////////
// Decoded control of the held instruction
// Driven by the decoder, read by operand and write-back logic
////////////////////////////////////////////////////////////

`default_nettype none

interface id_dec_if;

  // Register file addressing and write-back
  logic [id_pkg::reg_addr_w-1:0] raddr_a;
  logic [id_pkg::reg_addr_w-1:0] raddr_b;
  logic [id_pkg::reg_addr_w-1:0] waddr;
  logic                          rf_we;
  id_pkg::rf_wd_sel_e            rf_wd_sel;

  // ALU control
  id_pkg::alu_op_e               alu_operator;
  id_pkg::op_a_sel_e             op_a_sel;
  id_pkg::op_b_sel_e             op_b_sel;
  id_pkg::imm_b_sel_e            imm_b_sel;

  // Sign-extended immediates
  logic [id_pkg::xlen-1:0]       imm_i;
  logic [id_pkg::xlen-1:0]       imm_s;
  logic [id_pkg::xlen-1:0]       imm_b;
  logic [id_pkg::xlen-1:0]       imm_u;
  logic [id_pkg::xlen-1:0]       imm_j;

  // Memory access
  logic                          data_req;
  logic                          data_we;
  id_pkg::data_type_e            data_type;
  logic                          data_sign_ext;

  // Instruction class
  logic                          branch;
  logic                          jump;
  logic                          illegal;

  modport decoder (
    output raddr_a, raddr_b, waddr, rf_we, rf_wd_sel,
    output alu_operator, op_a_sel, op_b_sel, imm_b_sel,
    output imm_i, imm_s, imm_b, imm_u, imm_j,
    output data_req, data_we, data_type, data_sign_ext,
    output branch, jump, illegal
  );

  modport operands (
    input alu_operator, op_a_sel, op_b_sel, imm_b_sel,
    input imm_i, imm_s, imm_b, imm_u, imm_j
  );

  modport wb (
    input data_req, branch, jump, illegal,
    input rf_we, rf_wd_sel, waddr
  );

endinterface

`default_nettype wire

// File: id_decoder.sv
////////////////////////////////////////////////////////////
// Combinational RV32I decoder for the held instruction
// Fills the decoded-control bundle and the immediates
////////////////////////////////////////////////////////////

`default_nettype none

module id_decoder #(
  parameter bit rv32e = 1'b0
) (
  input  logic [id_pkg::xlen-1:0] instr_i,
  id_dec_if.decoder               dec
);

  logic [2:0]                    funct3;
  logic [6:0]                    funct7;
  logic [id_pkg::reg_addr_w-1:0] rs1;
  logic [id_pkg::reg_addr_w-1:0] rs2;
  logic [id_pkg::reg_addr_w-1:0] rd;
  logic                          use_rs1;
  logic                          use_rs2;
  logic                          use_rd;
  logic                          illegal_enc;
  logic                          illegal_reg;

  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign rd     = instr_i[11:7];

  assign dec.raddr_a = rs1;
  assign dec.raddr_b = rs2;
  assign dec.waddr   = rd;

  ////////////////////////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////////////////////////

  assign dec.imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign dec.imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign dec.imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                      instr_i[30:25], instr_i[11:8], 1'b0};
  assign dec.imm_u = {instr_i[31:12], 12'b0};
  assign dec.imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                      instr_i[30:21], 1'b0};

  ////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////

  always_comb begin : decode
    illegal_enc       = 1'b0;
    use_rs1           = 1'b0;
    use_rs2           = 1'b0;
    use_rd            = 1'b0;
    dec.rf_we         = 1'b0;
    dec.rf_wd_sel     = id_pkg::RF_WD_EX;
    dec.alu_operator  = id_pkg::ALU_ADD;
    dec.op_a_sel      = id_pkg::OP_A_REG_A;
    dec.op_b_sel      = id_pkg::OP_B_IMM;
    dec.imm_b_sel     = id_pkg::IMM_B_I;
    dec.data_req      = 1'b0;
    dec.data_we       = 1'b0;
    dec.data_type     = id_pkg::DT_WORD;
    dec.data_sign_ext = 1'b0;
    dec.branch        = 1'b0;
    dec.jump          = 1'b0;

    case (id_pkg::opcode_e'(instr_i[6:0]))
      id_pkg::OPCODE_LUI: begin
        use_rd        = 1'b1;
        dec.rf_we     = 1'b1;
        dec.op_a_sel  = id_pkg::OP_A_ZERO;
        dec.imm_b_sel = id_pkg::IMM_B_U;
      end
      id_pkg::OPCODE_AUIPC: begin
        use_rd        = 1'b1;
        dec.rf_we     = 1'b1;
        dec.op_a_sel  = id_pkg::OP_A_CURRPC;
        dec.imm_b_sel = id_pkg::IMM_B_U;
      end
      id_pkg::OPCODE_JAL: begin
        // ALU only forms the link value PC + 4
        use_rd        = 1'b1;
        dec.rf_we     = 1'b1;
        dec.jump      = 1'b1;
        dec.op_a_sel  = id_pkg::OP_A_CURRPC;
        dec.imm_b_sel = id_pkg::IMM_B_INCR_PC;
      end
      id_pkg::OPCODE_BRANCH: begin
        use_rs1      = 1'b1;
        use_rs2      = 1'b1;
        dec.branch   = 1'b1;
        dec.op_b_sel = id_pkg::OP_B_REG_B;
        case (funct3)
          3'b000:  dec.alu_operator = id_pkg::ALU_EQ;
          3'b001:  dec.alu_operator = id_pkg::ALU_NE;
          3'b100:  dec.alu_operator = id_pkg::ALU_LT;
          3'b101:  dec.alu_operator = id_pkg::ALU_GE;
          3'b110:  dec.alu_operator = id_pkg::ALU_LTU;
          3'b111:  dec.alu_operator = id_pkg::ALU_GEU;
          default: illegal_enc = 1'b1;
        endcase
      end
      id_pkg::OPCODE_LOAD: begin
        use_rs1           = 1'b1;
        use_rd            = 1'b1;
        dec.rf_we         = 1'b1;
        dec.rf_wd_sel     = id_pkg::RF_WD_LSU;
        dec.data_req      = 1'b1;
        dec.data_sign_ext = ~funct3[2];
        case (funct3)
          3'b000, 3'b100: dec.data_type = id_pkg::DT_BYTE;
          3'b001, 3'b101: dec.data_type = id_pkg::DT_HALF;
          3'b010:         dec.data_type = id_pkg::DT_WORD;
          default:        illegal_enc = 1'b1;
        endcase
      end
      id_pkg::OPCODE_STORE: begin
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
        dec.data_req  = 1'b1;
        dec.data_we   = 1'b1;
        dec.imm_b_sel = id_pkg::IMM_B_S;
        case (funct3)
          3'b000:  dec.data_type = id_pkg::DT_BYTE;
          3'b001:  dec.data_type = id_pkg::DT_HALF;
          3'b010:  dec.data_type = id_pkg::DT_WORD;
          default: illegal_enc = 1'b1;
        endcase
      end
      id_pkg::OPCODE_OP_IMM: begin
        use_rs1   = 1'b1;
        use_rd    = 1'b1;
        dec.rf_we = 1'b1;
        case (funct3)
          3'b000: dec.alu_operator = id_pkg::ALU_ADD;
          3'b010: dec.alu_operator = id_pkg::ALU_SLT;
          3'b011: dec.alu_operator = id_pkg::ALU_SLTU;
          3'b100: dec.alu_operator = id_pkg::ALU_XOR;
          3'b110: dec.alu_operator = id_pkg::ALU_OR;
          3'b111: dec.alu_operator = id_pkg::ALU_AND;
          3'b001: begin
            dec.alu_operator = id_pkg::ALU_SLL;
            illegal_enc      = (funct7 != 7'b0000000);
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            dec.alu_operator = funct7[5] ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
            illegal_enc      = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        endcase
      end
      id_pkg::OPCODE_OP: begin
        use_rs1      = 1'b1;
        use_rs2      = 1'b1;
        use_rd       = 1'b1;
        dec.rf_we    = 1'b1;
        dec.op_b_sel = id_pkg::OP_B_REG_B;
        case ({funct7, funct3})
          10'b0000000_000: dec.alu_operator = id_pkg::ALU_ADD;
          10'b0100000_000: dec.alu_operator = id_pkg::ALU_SUB;
          10'b0000000_001: dec.alu_operator = id_pkg::ALU_SLL;
          10'b0000000_010: dec.alu_operator = id_pkg::ALU_SLT;
          10'b0000000_011: dec.alu_operator = id_pkg::ALU_SLTU;
          10'b0000000_100: dec.alu_operator = id_pkg::ALU_XOR;
          10'b0000000_101: dec.alu_operator = id_pkg::ALU_SRL;
          10'b0100000_101: dec.alu_operator = id_pkg::ALU_SRA;
          10'b0000000_110: dec.alu_operator = id_pkg::ALU_OR;
          10'b0000000_111: dec.alu_operator = id_pkg::ALU_AND;
          default:         illegal_enc = 1'b1;
        endcase
      end
      default: illegal_enc = 1'b1;
    endcase

    // RV32E has no registers x16 to x31
    illegal_reg = rv32e && ((use_rs1 && rs1[4]) || (use_rs2 && rs2[4]) ||
                            (use_rd && rd[4]));
    dec.illegal = illegal_enc || illegal_reg;

    // An illegal word must not start any activity
    if (dec.illegal) begin
      dec.rf_we    = 1'b0;
      dec.data_req = 1'b0;
      dec.branch   = 1'b0;
      dec.jump     = 1'b0;
    end
  end

  // The write-back FSM relies on at most one multicycle class
  always_comb begin : class_check
    assert ($onehot0({dec.data_req, dec.branch, dec.jump}))
      else $error("More than one multicycle class decoded");
  end

endmodule

`default_nettype wire

// File: id_register_file.sv
////////////////////////////////////////////////////////////
// Flip-flop register file, two async reads, one write
// x0 reads as zero, RV32E keeps 16 registers
////////////////////////////////////////////////////////////

`default_nettype none

module id_register_file #(
  parameter bit rv32e = 1'b0
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [id_pkg::reg_addr_w-1:0] raddr_a_i,
  input  logic [id_pkg::reg_addr_w-1:0] raddr_b_i,
  output logic [id_pkg::xlen-1:0]       rdata_a_o,
  output logic [id_pkg::xlen-1:0]       rdata_b_o,
  input  logic [id_pkg::reg_addr_w-1:0] waddr_i,
  input  logic [id_pkg::xlen-1:0]       wdata_i,
  input  logic                          we_i
);

  localparam int num_regs = rv32e ? 16 : 32;

  // x0 has no storage
  logic [id_pkg::xlen-1:0] mem [1:num_regs-1];

  function automatic logic [id_pkg::xlen-1:0] read_reg(
    input logic [id_pkg::reg_addr_w-1:0] addr
  );
    if (addr == '0 || int'(addr) >= num_regs) begin
      return '0;
    end
    return mem[addr];
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_write
    if (!rst_ni) begin
      for (int i = 1; i < num_regs; i++) begin
        mem[i] <= '0;
      end
    end else if (we_i && waddr_i != '0 && int'(waddr_i) < num_regs) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = read_reg(raddr_a_i);
  assign rdata_b_o = read_reg(raddr_b_i);

  // Decoder must have flagged any index beyond the file as illegal
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    we_i |-> int'(waddr_i) < num_regs)
    else $error("Register write beyond register count");

endmodule

`default_nettype wire

// File: id_operand_mux.sv
////////////////////////////////////////////////////////////
// ALU operand selection for the decode stage
// Picks the immediate, then operand A and operand B
////////////////////////////////////////////////////////////

`default_nettype none

module id_operand_mux (
  id_dec_if.operands              dec,
  input  logic [id_pkg::xlen-1:0] rdata_a_i,
  input  logic [id_pkg::xlen-1:0] rdata_b_i,
  input  logic [id_pkg::xlen-1:0] pc_i,
  output logic [id_pkg::xlen-1:0] operand_a_o,
  output logic [id_pkg::xlen-1:0] operand_b_o,
  output id_pkg::alu_op_e         alu_operator_o
);

  logic [id_pkg::xlen-1:0] imm_b;

  // Immediate for operand B
  always_comb begin : imm_b_mux
    case (dec.imm_b_sel)
      id_pkg::IMM_B_I:       imm_b = dec.imm_i;
      id_pkg::IMM_B_S:       imm_b = dec.imm_s;
      id_pkg::IMM_B_B:       imm_b = dec.imm_b;
      id_pkg::IMM_B_U:       imm_b = dec.imm_u;
      id_pkg::IMM_B_J:       imm_b = dec.imm_j;
      // No compressed support, so always a full word
      id_pkg::IMM_B_INCR_PC: imm_b = 32'h4;
      default:               imm_b = '0;
    endcase
  end

  always_comb begin : operand_a_mux
    case (dec.op_a_sel)
      id_pkg::OP_A_REG_A:  operand_a_o = rdata_a_i;
      id_pkg::OP_A_CURRPC: operand_a_o = pc_i;
      default:             operand_a_o = '0;
    endcase
  end

  assign operand_b_o = (dec.op_b_sel == id_pkg::OP_B_IMM) ? imm_b : rdata_b_i;

  assign alu_operator_o = dec.alu_operator;

endmodule

`default_nettype wire

// File: id_wb_fsm.sv
////////////////////////////////////////////////////////////
// ID-EX/WB control, stalls multicycle instructions
// Gates the register write to the completion cycle
////////////////////////////////////////////////////////////

`default_nettype none

module id_wb_fsm (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  id_dec_if.wb                    dec,
  input  logic                    instr_new_i,
  input  logic                    branch_decision_i,
  input  logic                    ex_valid_i,
  input  logic                    lsu_valid_i,
  input  logic [id_pkg::xlen-1:0] wdata_ex_i,
  input  logic [id_pkg::xlen-1:0] wdata_lsu_i,
  output logic                    rf_we_o,
  output logic [id_pkg::xlen-1:0] rf_wdata_o,
  output logic                    data_req_o,
  output logic                    instr_ret_o,
  output logic                    branch_set_o
);

  typedef enum logic {
    IDLE,
    WAIT_MULTICYCLE
  } id_fsm_e;

  id_fsm_e state_q, state_n;
  logic    branch_set_q, branch_set_n;
  logic    mc_done_q, mc_done_n;
  logic    instr_executing;
  logic    unit_done;
  logic    rf_we_wb;

  // Held instruction is live in its strobe cycle or while stalled
  assign instr_executing = instr_new_i | ~mc_done_q;
  assign data_req_o      = instr_executing & dec.data_req;

  // LSU finishes loads and stores, EX everything else
  assign unit_done = dec.data_req ? lsu_valid_i : ex_valid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_regs
    if (!rst_ni) begin
      state_q      <= IDLE;
      branch_set_q <= 1'b0;
      mc_done_q    <= 1'b1;
    end else begin
      state_q      <= state_n;
      branch_set_q <= branch_set_n;
      mc_done_q    <= mc_done_n;
    end
  end

  always_comb begin : fsm_next
    state_n      = state_q;
    mc_done_n    = mc_done_q;
    branch_set_n = 1'b0;
    rf_we_wb     = 1'b0;
    instr_ret_o  = 1'b0;

    case (state_q)
      IDLE: begin
        if (instr_new_i && !dec.illegal) begin
          if (dec.data_req || dec.jump || (dec.branch && branch_decision_i)) begin
            state_n      = WAIT_MULTICYCLE;
            mc_done_n    = 1'b0;
            branch_set_n = dec.branch;
          end else begin
            // Single cycle, including a branch not taken
            rf_we_wb    = dec.rf_we;
            instr_ret_o = 1'b1;
          end
        end
      end
      WAIT_MULTICYCLE: begin
        if (unit_done) begin
          state_n     = IDLE;
          mc_done_n   = 1'b1;
          rf_we_wb    = dec.rf_we;
          instr_ret_o = 1'b1;
        end
      end
      default: state_n = IDLE;
    endcase
  end

  // Writes to x0 are dropped here already
  assign rf_we_o      = rf_we_wb & (dec.waddr != '0);
  assign rf_wdata_o   = (dec.rf_wd_sel == id_pkg::RF_WD_LSU) ? wdata_lsu_i : wdata_ex_i;
  assign branch_set_o = branch_set_q;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // Fetch side waits for completion before the next strobe
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_i |-> state_q == IDLE)
    else $error("Instruction strobe while stalled");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (instr_new_i && dec.branch) |-> !$isunknown(branch_decision_i))
    else $error("Branch decision unknown at strobe");

endmodule

`default_nettype wire

// File: id_stage.sv
////////////////////////////////////////////////////////////
// RV32I decode stage top level with the register file
// Decoder, operand mux and write-back FSM on plain ports
////////////////////////////////////////////////////////////

`default_nettype none

module id_stage #(
  parameter bit rv32e = 1'b0
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Fetch side
  input  logic                    instr_new_i,
  input  logic [id_pkg::xlen-1:0] instr_rdata_i,
  input  logic [id_pkg::xlen-1:0] pc_id_i,

  // Execute and LSU completion
  input  logic                    branch_decision_i,
  input  logic                    ex_valid_i,
  input  logic                    lsu_valid_i,
  input  logic [id_pkg::xlen-1:0] regfile_wdata_ex_i,
  input  logic [id_pkg::xlen-1:0] regfile_wdata_lsu_i,

  // ALU
  output id_pkg::alu_op_e         alu_operator_o,
  output logic [id_pkg::xlen-1:0] alu_operand_a_o,
  output logic [id_pkg::xlen-1:0] alu_operand_b_o,

  // LSU
  output logic                    data_req_o,
  output logic                    data_we_o,
  output id_pkg::data_type_e      data_type_o,
  output logic                    data_sign_ext_o,
  output logic [id_pkg::xlen-1:0] data_wdata_o,

  output logic                    illegal_insn_o,
  output logic                    instr_ret_o,
  output logic                    branch_set_o
);

  logic [id_pkg::xlen-1:0] rf_rdata_a;
  logic [id_pkg::xlen-1:0] rf_rdata_b;
  logic [id_pkg::xlen-1:0] rf_wdata;
  logic                    rf_we;

  id_dec_if dec_if ();

  id_decoder #(
    .rv32e (rv32e)
  ) decoder0 (
    .instr_i (instr_rdata_i),
    .dec     (dec_if.decoder)
  );

  id_register_file #(
    .rv32e (rv32e)
  ) regfile0 (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (dec_if.raddr_a),
    .raddr_b_i (dec_if.raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .waddr_i   (dec_if.waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we)
  );

  id_operand_mux opmux0 (
    .dec            (dec_if.operands),
    .rdata_a_i      (rf_rdata_a),
    .rdata_b_i      (rf_rdata_b),
    .pc_i           (pc_id_i),
    .operand_a_o    (alu_operand_a_o),
    .operand_b_o    (alu_operand_b_o),
    .alu_operator_o (alu_operator_o)
  );

  id_wb_fsm wbfsm0 (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .dec               (dec_if.wb),
    .instr_new_i       (instr_new_i),
    .branch_decision_i (branch_decision_i),
    .ex_valid_i        (ex_valid_i),
    .lsu_valid_i       (lsu_valid_i),
    .wdata_ex_i        (regfile_wdata_ex_i),
    .wdata_lsu_i       (regfile_wdata_lsu_i),
    .rf_we_o           (rf_we),
    .rf_wdata_o        (rf_wdata),
    .data_req_o        (data_req_o),
    .instr_ret_o       (instr_ret_o),
    .branch_set_o      (branch_set_o)
  );

  // LSU side fields straight from the decoder
  assign data_we_o       = dec_if.data_we;
  assign data_type_o     = dec_if.data_type;
  assign data_sign_ext_o = dec_if.data_sign_ext;
  assign data_wdata_o    = rf_rdata_b;

  // Reported once, in the strobe cycle
  assign illegal_insn_o = instr_new_i & dec_if.illegal;

endmodule

`default_nettype wire

// File: tb_id_stage.sv
////////////////////////////////////////////////////////////
// Testbench for the RV32I decode stage
// Applies a table of instructions, checks the DUT outputs
// and reads every register back at the end
////////////////////////////////////////////////////////////

`default_nettype none

module tb_id_stage;

  localparam int clk_period     = 100;
  localparam int sample_dly     = 25;
  localparam int timeout_cycles = 20;

  // Short names for the stimulus table
  localparam id_pkg::alu_op_e    op_add  = id_pkg::ALU_ADD;
  localparam id_pkg::alu_op_e    op_sub  = id_pkg::ALU_SUB;
  localparam id_pkg::alu_op_e    op_sra  = id_pkg::ALU_SRA;
  localparam id_pkg::alu_op_e    op_slt  = id_pkg::ALU_SLT;
  localparam id_pkg::alu_op_e    op_eq   = id_pkg::ALU_EQ;
  localparam id_pkg::alu_op_e    op_ne   = id_pkg::ALU_NE;
  localparam id_pkg::data_type_e dt_word = id_pkg::DT_WORD;
  localparam id_pkg::data_type_e dt_half = id_pkg::DT_HALF;
  localparam id_pkg::data_type_e dt_byte = id_pkg::DT_BYTE;

  typedef struct packed {
    logic [31:0]        instr;
    logic [31:0]        pc;
    logic               taken;
    logic [31:0]        wb;
    id_pkg::alu_op_e    op;
    logic [31:0]        opa;
    logic [31:0]        opb;
    id_pkg::data_type_e dtype;
    logic               sext;
    logic               writes;
    logic               illegal;
  } entry_t;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  instr_new_i;
  logic [31:0]           instr_rdata_i;
  logic [31:0]           pc_id_i;
  logic                  branch_decision_i;
  logic                  ex_valid_i;
  logic                  lsu_valid_i;
  logic [31:0]           regfile_wdata_ex_i;
  logic [31:0]           regfile_wdata_lsu_i;
  id_pkg::alu_op_e       alu_operator_o;
  logic [31:0]           alu_operand_a_o;
  logic [31:0]           alu_operand_b_o;
  logic                  data_req_o;
  logic                  data_we_o;
  id_pkg::data_type_e    data_type_o;
  logic                  data_sign_ext_o;
  logic [31:0]           data_wdata_o;
  logic                  illegal_insn_o;
  logic                  instr_ret_o;
  logic                  branch_set_o;

  entry_t                stim_q [$];
  logic [31:0]           ref_regs [32];

  id_stage #(
    .rv32e (1'b0)
  ) dut0 (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_new_i         (instr_new_i),
    .instr_rdata_i       (instr_rdata_i),
    .pc_id_i             (pc_id_i),
    .branch_decision_i   (branch_decision_i),
    .ex_valid_i          (ex_valid_i),
    .lsu_valid_i         (lsu_valid_i),
    .regfile_wdata_ex_i  (regfile_wdata_ex_i),
    .regfile_wdata_lsu_i (regfile_wdata_lsu_i),
    .alu_operator_o      (alu_operator_o),
    .alu_operand_a_o     (alu_operand_a_o),
    .alu_operand_b_o     (alu_operand_b_o),
    .data_req_o          (data_req_o),
    .data_we_o           (data_we_o),
    .data_type_o         (data_type_o),
    .data_sign_ext_o     (data_sign_ext_o),
    .data_wdata_o        (data_wdata_o),
    .illegal_insn_o      (illegal_insn_o),
    .instr_ret_o         (instr_ret_o),
    .branch_set_o        (branch_set_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // PC advances by one word per table row
  task automatic add_entry(input logic [31:0] instr, input int taken,
                           input logic [31:0] wb, input id_pkg::alu_op_e op,
                           input logic [31:0] opa, input logic [31:0] opb,
                           input id_pkg::data_type_e dtype, input int sext,
                           input int writes, input int illegal);
    entry_t e;
    e.instr   = instr;
    e.pc      = 32'h1000 + 4 * stim_q.size();
    e.taken   = (taken != 0);
    e.wb      = wb;
    e.op      = op;
    e.opa     = opa;
    e.opb     = opb;
    e.dtype   = dtype;
    e.sext    = (sext != 0);
    e.writes  = (writes != 0);
    e.illegal = (illegal != 0);
    stim_q.push_back(e);
  endtask

  task automatic load_table();
    //        instr       taken wb         op      opa          opb          type  sx wr il
    add_entry('h12300093, 0, 'h123,      op_add, 'h0,        'h123,      dt_word, 0, 1, 0);
    add_entry('hFFB00113, 0, 'hFFFFFFFB, op_add, 'h0,        'hFFFFFFFB, dt_word, 0, 1, 0);
    add_entry('hABCDE1B7, 0, 'hABCDE000, op_add, 'h0,        'hABCDE000, dt_word, 0, 1, 0);
    add_entry('h00001217, 0, 'h200C,     op_add, 'h100C,     'h1000,     dt_word, 0, 1, 0);
    add_entry('h002082B3, 0, 'h11E,      op_add, 'h123,      'hFFFFFFFB, dt_word, 0, 1, 0);
    add_entry('h40208333, 0, 'h128,      op_sub, 'h123,      'hFFFFFFFB, dt_word, 0, 1, 0);
    add_entry('h40115393, 0, 'hFFFFFFFD, op_sra, 'hFFFFFFFB, 'h401,      dt_word, 0, 1, 0);
    add_entry('h00112433, 0, 'h1,        op_slt, 'hFFFFFFFB, 'h123,      dt_word, 0, 1, 0);
    // Write to x0 is dropped, then x0 is read back
    add_entry('h00508013, 0, 'h128,      op_add, 'h123,      'h5,        dt_word, 0, 1, 0);
    add_entry('h001004B3, 0, 'h123,      op_add, 'h0,        'h123,      dt_word, 0, 1, 0);
    // Loads and stores
    add_entry('h0080A503, 0, 'hCAFEF00D, op_add, 'h123,      'h8,        dt_word, 1, 1, 0);
    add_entry('hFFF1C583, 0, 'hA5,       op_add, 'hABCDE000, 'hFFFFFFFF, dt_byte, 0, 1, 0);
    add_entry('h00201603, 0, 'hFFFF8001, op_add, 'h0,        'h2,        dt_half, 1, 1, 0);
    add_entry('h00A0A223, 0, 'hDEADBEEF, op_add, 'h123,      'h4,        dt_word, 0, 0, 0);
    add_entry('hFEC10823, 0, 'hDEADBEEF, op_add, 'hFFFFFFFB, 'hFFFFFFF0, dt_byte, 0, 0, 0);
    // Branch not taken, branch taken, then JAL
    add_entry('h00908463, 0, 'hBAD00001, op_eq,  'h123,      'h123,      dt_word, 0, 0, 0);
    add_entry('hFE111EE3, 1, 'hBAD00002, op_ne,  'hFFFFFFFB, 'h123,      dt_word, 0, 0, 0);
    add_entry('h010006EF, 0, 'h1048,     op_add, 'h1044,     'h4,        dt_word, 0, 1, 0);
    // Illegal words, among them MUL and JALR
    add_entry('h00000000, 0, 'hBAD00003, op_add, 'h0,        'h0,        dt_word, 0, 0, 1);
    add_entry('hFFFFFFFF, 0, 'hBAD00004, op_add, 'h0,        'h0,        dt_word, 0, 0, 1);
    add_entry('h02208333, 0, 'hBAD00005, op_add, 'h0,        'h0,        dt_word, 0, 0, 1);
    add_entry('h000080E7, 0, 'hBAD00006, op_add, 'h0,        'h0,        dt_word, 0, 0, 1);
    // Link value and byte load read back
    add_entry('h00B68733, 0, 'h10ED,     op_add, 'h1048,     'hA5,       dt_word, 0, 1, 0);
  endtask

  task automatic run_entry(input entry_t e);
    logic [6:0] opcode;
    logic [4:0] rd;
    logic [4:0] rs2;
    logic       is_load;
    logic       is_store;
    logic       is_mem;
    logic       multi;
    int         delay;
    int         cycles;
    opcode   = e.instr[6:0];
    rd       = e.instr[11:7];
    rs2      = e.instr[24:20];
    is_load  = !e.illegal && (opcode == id_pkg::OPCODE_LOAD);
    is_store = !e.illegal && (opcode == id_pkg::OPCODE_STORE);
    is_mem   = is_load || is_store;
    multi    = is_mem || (!e.illegal && (opcode == id_pkg::OPCODE_JAL ||
               (opcode == id_pkg::OPCODE_BRANCH && e.taken)));

    // Strobe cycle
    @(negedge clk_i);
    instr_new_i         = 1'b1;
    instr_rdata_i       = e.instr;
    pc_id_i             = e.pc;
    branch_decision_i   = e.taken;
    // The source that must not be written carries the inverted value
    regfile_wdata_ex_i  = is_load ? ~e.wb : e.wb;
    regfile_wdata_lsu_i = is_load ? e.wb : ~e.wb;
    ex_valid_i          = 1'b0;
    lsu_valid_i         = 1'b0;
    #(sample_dly);
    check_value("illegal_insn_o", 32'(illegal_insn_o), 32'(e.illegal));
    check_value("instr_ret_o", 32'(instr_ret_o), 32'(!e.illegal && !multi));
    check_value("data_req_o", 32'(data_req_o), 32'(is_mem));
    check_value("branch_set_o", 32'(branch_set_o), 32'h0);
    if (!e.illegal) begin
      check_value("alu_operator_o", 32'(alu_operator_o), 32'(e.op));
      check_value("alu_operand_a_o", alu_operand_a_o, e.opa);
      check_value("alu_operand_b_o", alu_operand_b_o, e.opb);
      check_value("data_we_o", 32'(data_we_o), 32'(is_store));
    end
    if (is_mem) begin
      check_value("data_type_o", 32'(data_type_o), 32'(e.dtype));
      check_value("data_sign_ext_o", 32'(data_sign_ext_o), 32'(e.sext));
    end
    if (is_store) begin
      check_value("data_wdata_o", data_wdata_o, ref_regs[rs2]);
    end

    // Stall until the serving unit reports completion
    if (multi) begin
      delay  = $urandom % 4;
      cycles = 0;
      do begin
        @(negedge clk_i);
        instr_new_i = 1'b0;
        ex_valid_i  = 1'b0;
        lsu_valid_i = 1'b0;
        cycles++;
        if (cycles == delay + 1) begin
          if (is_mem) begin
            lsu_valid_i = 1'b1;
          end else begin
            ex_valid_i = 1'b1;
          end
        end
        #(sample_dly);
        check_value("data_req_o", 32'(data_req_o), 32'(is_mem));
        check_value("branch_set_o", 32'(branch_set_o),
                    32'(opcode == id_pkg::OPCODE_BRANCH && cycles == 1));
        if (!instr_ret_o && cycles >= timeout_cycles) begin
          abort_run($sformatf("Timeout: instruction %h never retired", e.instr));
        end
      end while (!instr_ret_o);
      check_value("retire cycle", cycles, delay + 1);
    end

    // Illegal word must stay without retire
    if (e.illegal) begin
      @(negedge clk_i);
      instr_new_i = 1'b0;
      #(sample_dly);
      check_value("instr_ret_o", 32'(instr_ret_o), 32'h0);
      check_value("illegal_insn_o", 32'(illegal_insn_o), 32'h0);
    end

    if (!e.illegal && e.writes && rd != 5'd0) begin
      ref_regs[rd] = e.wb;
    end
  endtask

  initial begin : stimulus
    entry_t sweep;
    void'($urandom(69));
    rst_ni              = 1'b0;
    instr_new_i         = 1'b0;
    instr_rdata_i       = '0;
    pc_id_i             = '0;
    branch_decision_i   = 1'b0;
    ex_valid_i          = 1'b0;
    lsu_valid_i         = 1'b0;
    regfile_wdata_ex_i  = '0;
    regfile_wdata_lsu_i = '0;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    load_table();

    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    #(sample_dly);
    check_value("instr_ret_o", 32'(instr_ret_o), 32'h0);
    check_value("data_req_o", 32'(data_req_o), 32'h0);
    check_value("branch_set_o", 32'(branch_set_o), 32'h0);

    for (int i = 0; i < stim_q.size(); i++) begin
      run_entry(stim_q[i]);
    end

    // Read every register through ADD x0, xn, x0
    for (int n = 0; n < 32; n++) begin
      sweep.instr   = {12'h000, 5'(n), 3'b000, 5'b00000, 7'h33};
      sweep.pc      = 32'h2000 + 4 * n;
      sweep.taken   = 1'b0;
      sweep.wb      = 32'h5A5A0000 + n;
      sweep.op      = op_add;
      sweep.opa     = ref_regs[n];
      sweep.opb     = ref_regs[0];
      sweep.dtype   = dt_word;
      sweep.sext    = 1'b0;
      sweep.writes  = 1'b1;
      sweep.illegal = 1'b0;
      run_entry(sweep);
    end

    @(negedge clk_i);
    instr_new_i = 1'b0;
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
id_pkg.sv
id_dec_if.sv
id_decoder.sv
id_register_file.sv
id_operand_mux.sv
id_wb_fsm.sv
id_stage.sv
tb_id_stage.sv

// File: Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
FLAGS     ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Done: no errors"

clean:
	rm -rf $(BUILD_DIR)
